// File: list.f
rtl/lc4_pkg.sv
rtl/lc4_fwd_if.sv
rtl/lc4_xstage_if.sv
rtl/lc4_fetch.sv
rtl/lc4_regfile.sv
rtl/lc4_decode.sv
rtl/lc4_alu.sv
rtl/lc4_execute.sv
rtl/lc4_pipeline.sv
verification/tb_clock_gen.sv
verification/tb_lc4_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_lc4_pipeline -f list.f -o sim_lc4
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lc4 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1

// File: verification/tb_lc4_pipeline.sv
`timescale 1ns/1ps

module tb_lc4_pipeline;

    localparam int clk_period_ns = 40;
    localparam int num_insn      = 22;

    typedef struct packed {
        logic [15:0] insn;
        logic [15:0] val;
        logic        bubble;
    } entry_t;

    // program placed from 8200h with each expected write value and load bubble flag
    localparam entry_t prog_table [num_insn] = '{
        '{16'h9205, 16'h0005, 1'b0},  // const r1, #5
        '{16'h95FD, 16'hFFFD, 1'b0},  // const r2, #-3
        '{16'h1642, 16'h0002, 1'b0},  // add r3, r1, r2
        '{16'h18D1, 16'hFFFD, 1'b0},  // sub r4, r3, r1
        '{16'h1B3F, 16'hFFFC, 1'b0},  // add r5, r4, #-1
        '{16'h5D41, 16'h0004, 1'b0},  // and r6, r5, r1
        '{16'h5F88, 16'hFFFB, 1'b0},  // not r7, r6
        '{16'h53D2, 16'hFFFF, 1'b0},  // or r1, r7, r2
        '{16'h545B, 16'hFFFD, 1'b0},  // xor r2, r1, r3
        '{16'h56A7, 16'h0005, 1'b0},  // and r3, r2, #7
        '{16'h9000, 16'h0000, 1'b0},  // const r0, #0
        '{16'h0000, 16'h0000, 1'b0},  // nop
        '{16'h9840, 16'h0040, 1'b0},  // const r4, #40h
        '{16'h16E3, 16'h0008, 1'b0},  // add r3, r3, #3
        '{16'h7701, 16'h0000, 1'b0},  // str r3, r4, #1
        '{16'h6B01, 16'h0008, 1'b0},  // ldr r5, r4, #1
        '{16'h1D45, 16'h0010, 1'b1},  // add r6, r5, r5
        '{16'h6F02, 16'h3C42, 1'b0},  // ldr r7, r4, #2
        '{16'h7F03, 16'h0000, 1'b0},  // str r7, r4, #3
        '{16'h6303, 16'h3C42, 1'b0},  // ldr r1, r4, #3
        '{16'h9401, 16'h0001, 1'b0},  // const r2, #1
        '{16'h1652, 16'h3C41, 1'b0}   // sub r3, r1, r2
    };

    logic        gwe;
    logic        reset;
    logic [15:0] imem_addr;
    logic [15:0] imem_insn;
    logic [15:0] dmem_addr;
    logic        dmem_we;
    logic [15:0] dmem_towrite;
    logic [15:0] dmem_data;
    logic [1:0]  test_stall;
    logic [15:0] test_pc;
    logic [15:0] test_insn;
    logic        test_regfile_we;
    logic [2:0]  test_regfile_wsel;
    logic [15:0] test_regfile_data;
    logic        test_nzp_we;
    logic [2:0]  test_nzp_bits;

    logic [15:0] dmem [16];
    logic [31:0] store_q [$];
    logic        exp_we    [num_insn];
    logic [2:0]  exp_rd    [num_insn];
    logic [15:0] exp_val   [num_insn];
    logic        exp_st    [num_insn];
    logic [15:0] exp_addr  [num_insn];
    logic [15:0] exp_sdata [num_insn];
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_passed = 0;

    tb_clock_gen u_clock_gen (
        .gwe     (gwe),
        .o_reset (reset)
    );

    lc4_pipeline dut (
        .gwe                 (gwe),
        .i_reset             (reset),
        .o_imem_addr         (imem_addr),
        .i_imem_insn         (imem_insn),
        .o_dmem_addr         (dmem_addr),
        .o_dmem_we           (dmem_we),
        .o_dmem_towrite      (dmem_towrite),
        .i_dmem_data         (dmem_data),
        .o_test_stall        (test_stall),
        .o_test_pc           (test_pc),
        .o_test_insn         (test_insn),
        .o_test_regfile_we   (test_regfile_we),
        .o_test_regfile_wsel (test_regfile_wsel),
        .o_test_regfile_data (test_regfile_data),
        .o_test_nzp_we       (test_nzp_we),
        .o_test_nzp_bits     (test_nzp_bits)
    );

    // data memory window is 0040h..004Fh
    function automatic logic in_window(input logic [15:0] addr);
        return addr[15:4] == 12'h004;
    endfunction

    function automatic logic [15:0] preset_word(input logic [15:0] addr);
        return addr ^ 16'h3c00;
    endfunction

    function automatic logic [15:0] dmem_read(input logic [15:0] addr);
        return in_window(addr) ? dmem[addr[3:0]] : preset_word(addr);
    endfunction

    // words past the end of the program read as nop
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] offset;
        offset = addr - 16'h8200;
        if (addr >= 16'h8200 && offset < 16'(num_insn)) begin
            return prog_table[offset[4:0]].insn;
        end
        return 16'h0000;
    endfunction

    // both memories answer in the same cycle
    always_comb imem_insn = fetch_word(imem_addr);
    always_comb dmem_data = dmem_read(dmem_addr);

    always @(posedge gwe) begin
        if (reset) begin
            for (int k = 0; k < 16; k++) begin
                dmem[k] <= preset_word(16'h0040 + 16'(k));
            end
        end else if (dmem_we && in_window(dmem_addr)) begin
            dmem[dmem_addr[3:0]] <= dmem_towrite;
        end
    end

    // ISA model that runs the program in order with no pipeline
    task automatic build_expected();
        logic [15:0] mregs [8];
        logic [15:0] mmem [16];
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm5;
        logic [15:0] addr;
        for (int r = 0; r < 8; r++) begin
            mregs[r] = 16'h0000;
        end
        for (int k = 0; k < 16; k++) begin
            mmem[k] = preset_word(16'h0040 + 16'(k));
        end
        for (int i = 0; i < num_insn; i++) begin
            w          = prog_table[i].insn;
            a          = mregs[w[8:6]];
            b          = mregs[w[2:0]];
            imm5       = {{11{w[4]}}, w[4:0]};
            addr       = a + {{10{w[5]}}, w[5:0]};
            exp_we[i]  = 1'b1;
            exp_st[i]  = 1'b0;
            exp_rd[i]  = w[11:9];
            exp_val[i] = 16'h0000;
            case (w[15:12])
                4'b0001: begin
                    if (w[5]) begin
                        exp_val[i] = a + imm5;
                    end else if (w[4:3] == 2'b10) begin
                        exp_val[i] = a - b;
                    end else begin
                        exp_val[i] = a + b;
                    end
                end
                4'b0101: begin
                    if (w[5]) begin
                        exp_val[i] = a & imm5;
                    end else begin
                        case (w[4:3])
                            2'b00:   exp_val[i] = a & b;
                            2'b01:   exp_val[i] = ~a;
                            2'b10:   exp_val[i] = a | b;
                            default: exp_val[i] = a ^ b;
                        endcase
                    end
                end
                4'b0110: exp_val[i] = in_window(addr) ? mmem[addr[3:0]] : preset_word(addr);
                4'b0111: begin
                    exp_we[i]    = 1'b0;
                    exp_st[i]    = 1'b1;
                    exp_addr[i]  = addr;
                    exp_sdata[i] = mregs[w[11:9]];
                    if (in_window(addr)) begin
                        mmem[addr[3:0]] = mregs[w[11:9]];
                    end
                end
                4'b1001: exp_val[i] = {{7{w[8]}}, w[8:0]};
                default: exp_we[i] = 1'b0;
            endcase
            if (exp_we[i]) begin
                mregs[exp_rd[i]] = exp_val[i];
                if (exp_val[i] !== prog_table[i].val) begin
                    $display("table entry %0d expects %h but the ISA model computes %h",
                             i, prog_table[i].val, exp_val[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic log_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    // outputs are sampled on the falling edge and each data memory write is logged
    task automatic next_cycle();
        @(negedge gwe);
        if (dmem_we === 1'b1) begin
            store_q.push_back({dmem_addr, dmem_towrite});
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED", name);
        end
    endtask

    task automatic check_record(input int idx, input int bubbles);
        logic [2:0]  want_nzp;
        logic [31:0] st;
        want_nzp = exp_val[idx][15] ? 3'b100 : (exp_val[idx] == 16'h0000 ? 3'b010 : 3'b001);
        if (test_pc !== 16'h8200 + 16'(idx)) begin
            log_mismatch($sformatf("entry %0d retired pc %h", idx, test_pc));
        end
        if (test_insn !== prog_table[idx].insn) begin
            log_mismatch($sformatf("entry %0d retired insn %h, expected %h",
                                   idx, test_insn, prog_table[idx].insn));
        end
        if (bubbles != int'(prog_table[idx].bubble)) begin
            log_mismatch($sformatf("entry %0d preceded by %0d stall records", idx, bubbles));
        end
        if (test_regfile_we !== exp_we[idx] || test_nzp_we !== exp_we[idx]) begin
            log_mismatch($sformatf("entry %0d write enables %b/%b, expected %b", idx,
                                   test_regfile_we, test_nzp_we, exp_we[idx]));
        end
        if (exp_we[idx] && test_regfile_wsel !== exp_rd[idx]) begin
            log_mismatch($sformatf("entry %0d wrote r%0d, expected r%0d",
                                   idx, test_regfile_wsel, exp_rd[idx]));
        end
        if (exp_we[idx] && test_regfile_data !== prog_table[idx].val) begin
            log_mismatch($sformatf("entry %0d wrote %h, expected %h",
                                   idx, test_regfile_data, prog_table[idx].val));
        end
        if (exp_we[idx] && test_nzp_bits !== want_nzp) begin
            log_mismatch($sformatf("entry %0d nzp %b, expected %b", idx, test_nzp_bits, want_nzp));
        end
        if (exp_st[idx]) begin
            if (store_q.size() == 0) begin
                $display("entry %0d is a store but no data memory write was seen", idx);
                errors++;
            end else begin
                st = store_q.pop_front();
                if (st !== {exp_addr[idx], exp_sdata[idx]}) begin
                    log_mismatch($sformatf("entry %0d stored %h at %h, expected %h at %h", idx,
                                           st[15:0], st[31:16], exp_sdata[idx], exp_addr[idx]));
                end
            end
        end
    endtask

    initial begin : run_checks
        int bubbles;
        int errors_before;
        build_expected();
        next_cycle();
        while (reset !== 1'b0) begin
            next_cycle();
        end
        errors_before = errors;
        if (imem_addr !== 16'h8200) begin
            log_mismatch($sformatf("imem address %h after reset", imem_addr));
        end
        if (test_stall !== 2'd2) begin
            log_mismatch($sformatf("trace stall code %0d after reset", test_stall));
        end
        if (dmem_we !== 1'b0 || test_regfile_we !== 1'b0 || test_nzp_we !== 1'b0) begin
            log_mismatch("write enable high after reset");
        end
        finish_test("reset state", errors_before);
        for (int idx = 0; idx < num_insn; idx++) begin
            errors_before = errors;
            bubbles       = 0;
            next_cycle();
            while (test_stall !== 2'd0) begin
                if (test_stall === 2'd3) begin
                    bubbles++;
                    if (test_regfile_we !== 1'b0) begin
                        log_mismatch("stall record with regfile write enable high");
                    end
                end else if (test_regfile_we !== 1'b0 || test_nzp_we !== 1'b0) begin
                    log_mismatch("write enable high before the first retire");
                end
                next_cycle();
            end
            check_record(idx, bubbles);
            finish_test($sformatf("insn %0d at %h", idx, 16'h8200 + 16'(idx)), errors_before);
        end
        if (store_q.size() != 0) begin
            $display("%0d data memory writes were seen that no store explains", store_q.size());
            errors++;
        end
        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_passed, tests_run - tests_passed);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // bound on run length covering reset, pipeline fill and the program
    initial begin : watchdog
        #((num_insn + 20) * clk_period_ns);
        $display("timeout: the pipeline did not retire the whole program in time");
        $display("sim failed");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic gwe,
    output logic o_reset
);

    logic [2:0] reset_count = 3'd0;

    // 40 ns period
    initial begin
        gwe = 1'b0;
        forever #20 gwe = ~gwe;
    end

    // reset stays high for the first five rising edges
    always @(posedge gwe) begin
        if (reset_count != 3'd5) begin
            reset_count <= reset_count + 3'd1;
        end
    end

    assign o_reset = (reset_count != 3'd5);

endmodule

// File: rtl/lc4_pipeline.sv
`timescale 1ns/1ps

module lc4_pipeline (
    input  logic                          gwe,
    input  logic                          i_reset,
    output logic [lc4_pkg::word_w-1:0]    o_imem_addr,
    input  logic [lc4_pkg::word_w-1:0]    i_imem_insn,
    output logic [lc4_pkg::word_w-1:0]    o_dmem_addr,
    output logic                          o_dmem_we,
    output logic [lc4_pkg::word_w-1:0]    o_dmem_towrite,
    input  logic [lc4_pkg::word_w-1:0]    i_dmem_data,
    output logic [1:0]                    o_test_stall,
    output logic [lc4_pkg::word_w-1:0]    o_test_pc,
    output logic [lc4_pkg::word_w-1:0]    o_test_insn,
    output logic                          o_test_regfile_we,
    output logic [lc4_pkg::reg_sel_w-1:0] o_test_regfile_wsel,
    output logic [lc4_pkg::word_w-1:0]    o_test_regfile_data,
    output logic                          o_test_nzp_we,
    output logic [lc4_pkg::nzp_w-1:0]     o_test_nzp_bits
);

    logic [lc4_pkg::word_w-1:0] d_pc;
    logic [lc4_pkg::word_w-1:0] d_insn;
    logic                       hold;

    lc4_xstage_if xs_if ();
    lc4_fwd_if    fwd_if ();

    lc4_fetch u_fetch (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_hold      (hold),
        .i_imem_insn (i_imem_insn),
        .o_imem_addr (o_imem_addr),
        .o_d_pc      (d_pc),
        .o_d_insn    (d_insn)
    );

    lc4_decode u_decode (
        .gwe      (gwe),
        .i_reset  (i_reset),
        .i_d_pc   (d_pc),
        .i_d_insn (d_insn),
        .o_hold   (hold),
        .fwd      (fwd_if.consumer),
        .xs       (xs_if.producer)
    );

    lc4_execute u_execute (
        .gwe                 (gwe),
        .i_reset             (i_reset),
        .i_dmem_data         (i_dmem_data),
        .o_dmem_addr         (o_dmem_addr),
        .o_dmem_we           (o_dmem_we),
        .o_dmem_towrite      (o_dmem_towrite),
        .o_test_stall        (o_test_stall),
        .o_test_pc           (o_test_pc),
        .o_test_insn         (o_test_insn),
        .o_test_regfile_we   (o_test_regfile_we),
        .o_test_regfile_wsel (o_test_regfile_wsel),
        .o_test_regfile_data (o_test_regfile_data),
        .o_test_nzp_we       (o_test_nzp_we),
        .o_test_nzp_bits     (o_test_nzp_bits),
        .xs                  (xs_if.consumer),
        .fwd                 (fwd_if.producer)
    );

endmodule

// File: rtl/lc4_execute.sv
`timescale 1ns/1ps

module lc4_execute (
    input  logic                          gwe,
    input  logic                          i_reset,
    input  logic [lc4_pkg::word_w-1:0]    i_dmem_data,
    output logic [lc4_pkg::word_w-1:0]    o_dmem_addr,
    output logic                          o_dmem_we,
    output logic [lc4_pkg::word_w-1:0]    o_dmem_towrite,
    output logic [1:0]                    o_test_stall,
    output logic [lc4_pkg::word_w-1:0]    o_test_pc,
    output logic [lc4_pkg::word_w-1:0]    o_test_insn,
    output logic                          o_test_regfile_we,
    output logic [lc4_pkg::reg_sel_w-1:0] o_test_regfile_wsel,
    output logic [lc4_pkg::word_w-1:0]    o_test_regfile_data,
    output logic                          o_test_nzp_we,
    output logic [lc4_pkg::nzp_w-1:0]     o_test_nzp_bits,
    lc4_xstage_if.consumer                xs,
    lc4_fwd_if.producer                   fwd
);

    logic [lc4_pkg::word_w-1:0]    rs_val;
    logic [lc4_pkg::word_w-1:0]    rt_val;
    logic [lc4_pkg::word_w-1:0]    alu_result;
    logic                          mx_ok;
    // memory stage
    logic [lc4_pkg::word_w-1:0]    m_pc;
    logic [lc4_pkg::word_w-1:0]    m_insn;
    logic [lc4_pkg::reg_sel_w-1:0] m_rt_sel;
    logic [lc4_pkg::word_w-1:0]    m_rt_val;
    logic                          m_is_load;
    logic                          m_is_store;
    logic [1:0]                    m_stall;
    // writeback stage
    logic [lc4_pkg::word_w-1:0]    w_alu;
    logic [lc4_pkg::word_w-1:0]    w_load;
    logic                          w_is_load;

    // a load in memory has no data yet, so only WX can serve its dependents
    assign mx_ok = fwd.m_we && !m_is_load;

    assign rs_val = (mx_ok && fwd.m_rd == xs.rs_sel)    ? fwd.m_result :
                    (fwd.w_we && fwd.w_rd == xs.rs_sel) ? fwd.w_data   :
                    xs.rs_data;
    assign rt_val = (mx_ok && fwd.m_rd == xs.rt_sel)    ? fwd.m_result :
                    (fwd.w_we && fwd.w_rd == xs.rt_sel) ? fwd.w_data   :
                    xs.rt_data;

    lc4_alu u_alu (
        .i_insn    (xs.insn),
        .i_rs_data (rs_val),
        .i_rt_data (rt_val),
        .o_result  (alu_result)
    );

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            fwd.m_we     <= 1'b0;
            m_is_load    <= 1'b0;
            m_is_store   <= 1'b0;
            m_stall      <= lc4_pkg::stall_flush;
            fwd.w_we     <= 1'b0;
            w_is_load    <= 1'b0;
            o_test_stall <= lc4_pkg::stall_flush;
        end else begin
            fwd.m_we     <= xs.regfile_we;
            m_is_load    <= xs.is_load;
            m_is_store   <= xs.is_store;
            m_stall      <= xs.stall;
            fwd.w_we     <= fwd.m_we;
            w_is_load    <= m_is_load;
            o_test_stall <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc         <= xs.pc;
        m_insn       <= xs.insn;
        fwd.m_rd     <= xs.rd_sel;
        fwd.m_result <= alu_result;
        m_rt_sel     <= xs.rt_sel;
        m_rt_val     <= rt_val;
        o_test_pc    <= m_pc;
        o_test_insn  <= m_insn;
        fwd.w_rd     <= fwd.m_rd;
        w_alu        <= fwd.m_result;
        w_load       <= i_dmem_data;
    end

    // data port with WM bypass of the store data
    assign o_dmem_addr    = fwd.m_result;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = (fwd.w_we && fwd.w_rd == m_rt_sel) ? fwd.w_data : m_rt_val;

    assign fwd.w_data = w_is_load ? w_load : w_alu;

    assign o_test_regfile_we   = fwd.w_we;
    assign o_test_regfile_wsel = fwd.w_rd;
    assign o_test_regfile_data = fwd.w_data;
    // every writing instruction of the subset also sets nzp
    assign o_test_nzp_we       = fwd.w_we;
    assign o_test_nzp_bits     = fwd.w_data[lc4_pkg::word_w-1] ? lc4_pkg::nzp_n :
                                 (fwd.w_data == '0)            ? lc4_pkg::nzp_z :
                                 lc4_pkg::nzp_p;

endmodule

// File: rtl/lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu (
    input  logic [lc4_pkg::word_w-1:0] i_insn,
    input  logic [lc4_pkg::word_w-1:0] i_rs_data,
    input  logic [lc4_pkg::word_w-1:0] i_rt_data,
    output logic [lc4_pkg::word_w-1:0] o_result
);

    lc4_pkg::lc4_insn_u         insn;
    logic [lc4_pkg::word_w-1:0] imm5_sx;
    logic [lc4_pkg::word_w-1:0] off6_sx;
    logic [lc4_pkg::word_w-1:0] imm9_sx;

    assign insn    = i_insn;
    assign imm5_sx = {{11{insn.i.imm5[4]}}, insn.i.imm5};
    assign off6_sx = {{10{insn.m.off6[5]}}, insn.m.off6};
    assign imm9_sx = {{7{insn.c.imm9[8]}}, insn.c.imm9};

    always_comb begin
        o_result = '0;
        case (insn.r.opcode)
            lc4_pkg::op_arith: begin
                if (insn.i.imm_flag) begin
                    o_result = i_rs_data + imm5_sx;
                end else if (insn.r.subop == 3'b000) begin
                    o_result = i_rs_data + i_rt_data;
                end else if (insn.r.subop == 3'b010) begin
                    o_result = i_rs_data - i_rt_data;
                end
            end
            lc4_pkg::op_logic: begin
                if (insn.i.imm_flag) begin
                    o_result = i_rs_data & imm5_sx;
                end else begin
                    case (insn.r.subop)
                        3'b000:  o_result = i_rs_data & i_rt_data;
                        3'b001:  o_result = ~i_rs_data;
                        3'b010:  o_result = i_rs_data | i_rt_data;
                        default: o_result = i_rs_data ^ i_rt_data;
                    endcase
                end
            end
            // effective address for both memory forms
            lc4_pkg::op_ldr, lc4_pkg::op_str: o_result = i_rs_data + off6_sx;
            lc4_pkg::op_const:                o_result = imm9_sx;
            default: begin
            end
        endcase
    end

endmodule

// File: rtl/lc4_decode.sv
`timescale 1ns/1ps

module lc4_decode (
    input  logic                       gwe,
    input  logic                       i_reset,
    input  logic [lc4_pkg::word_w-1:0] i_d_pc,
    input  logic [lc4_pkg::word_w-1:0] i_d_insn,
    output logic                       o_hold,
    lc4_fwd_if.consumer                fwd,
    lc4_xstage_if.producer             xs
);

    lc4_pkg::lc4_insn_u            insn;
    logic [lc4_pkg::reg_sel_w-1:0] rs_sel;
    logic [lc4_pkg::reg_sel_w-1:0] rt_sel;
    logic [lc4_pkg::reg_sel_w-1:0] rd_sel;
    logic                          rs_re;
    logic                          rt_re;
    logic                          regfile_we;
    logic                          is_load;
    logic                          is_store;
    logic [lc4_pkg::word_w-1:0]    rf_rs_data;
    logic [lc4_pkg::word_w-1:0]    rf_rt_data;
    logic [1:0]                    d_stall;

    assign insn = i_d_insn;

    always_comb begin
        rs_sel     = insn.r.rs;
        rt_sel     = insn.r.rt;
        rd_sel     = insn.r.rd;
        rs_re      = 1'b0;
        rt_re      = 1'b0;
        regfile_we = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        case (insn.r.opcode)
            lc4_pkg::op_arith, lc4_pkg::op_logic: begin
                rs_re      = 1'b1;
                // NOT has no second source
                rt_re      = !insn.i.imm_flag &&
                             !(insn.r.opcode == lc4_pkg::op_logic && insn.r.subop == 3'b001);
                regfile_we = 1'b1;
            end
            lc4_pkg::op_ldr: begin
                rs_re      = 1'b1;
                regfile_we = 1'b1;
                is_load    = 1'b1;
            end
            lc4_pkg::op_str: begin
                rs_re    = 1'b1;
                rt_re    = 1'b1;
                rt_sel   = insn.m.rd;
                is_store = 1'b1;
            end
            lc4_pkg::op_const: begin
                regfile_we = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // stall on load-use unless only the store data depends on the load
    assign o_hold = xs.is_load &&
                    ((rs_re && rs_sel == xs.rd_sel) ||
                     (rt_re && rt_sel == xs.rd_sel && !is_store));

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs      (rs_sel),
        .i_rt      (rt_sel),
        .i_rd      (fwd.w_rd),
        .i_we      (fwd.w_we),
        .i_wdata   (fwd.w_data),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data)
    );

    // stall code of the word sitting in fetch/decode
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            d_stall <= lc4_pkg::stall_flush;
        end else if (!o_hold) begin
            d_stall <= lc4_pkg::stall_none;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset || o_hold) begin
            xs.regfile_we <= 1'b0;
            xs.is_load    <= 1'b0;
            xs.is_store   <= 1'b0;
            xs.insn       <= '0;
            xs.stall      <= i_reset ? lc4_pkg::stall_flush : lc4_pkg::stall_load;
        end else begin
            xs.regfile_we <= regfile_we;
            xs.is_load    <= is_load;
            xs.is_store   <= is_store;
            xs.insn       <= i_d_insn;
            xs.stall      <= d_stall;
        end
    end

    // operands take the value being written back this cycle
    always_ff @(posedge gwe) begin
        xs.pc      <= i_d_pc;
        xs.rs_sel  <= rs_sel;
        xs.rt_sel  <= rt_sel;
        xs.rd_sel  <= rd_sel;
        xs.rs_data <= (fwd.w_we && fwd.w_rd == rs_sel) ? fwd.w_data : rf_rs_data;
        xs.rt_data <= (fwd.w_we && fwd.w_rd == rt_sel) ? fwd.w_data : rf_rt_data;
    end

endmodule

// File: rtl/lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
    input  logic                          gwe,
    input  logic                          i_reset,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rs,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rt,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rd,
    input  logic                          i_we,
    input  logic [lc4_pkg::word_w-1:0]    i_wdata,
    output logic [lc4_pkg::word_w-1:0]    o_rs_data,
    output logic [lc4_pkg::word_w-1:0]    o_rt_data
);

    logic [lc4_pkg::word_w-1:0] regs [lc4_pkg::num_regs];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < lc4_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs_data = regs[i_rs];
    assign o_rt_data = regs[i_rt];

endmodule

// File: rtl/lc4_fetch.sv
`timescale 1ns/1ps

module lc4_fetch (
    input  logic                       gwe,
    input  logic                       i_reset,
    input  logic                       i_hold,
    input  logic [lc4_pkg::word_w-1:0] i_imem_insn,
    output logic [lc4_pkg::word_w-1:0] o_imem_addr,
    output logic [lc4_pkg::word_w-1:0] o_d_pc,
    output logic [lc4_pkg::word_w-1:0] o_d_insn
);

    logic [lc4_pkg::word_w-1:0] pc;

    // pc and the fetch/decode register share one enable
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc       <= lc4_pkg::reset_pc;
            o_d_pc   <= '0;
            o_d_insn <= '0;
        end else if (!i_hold) begin
            pc       <= pc + 16'd1;
            o_d_pc   <= pc;
            o_d_insn <= i_imem_insn;
        end
    end

    assign o_imem_addr = pc;

endmodule

// File: rtl/lc4_xstage_if.sv
`timescale 1ns/1ps

interface lc4_xstage_if;

    logic [lc4_pkg::word_w-1:0]    pc;
    logic [lc4_pkg::word_w-1:0]    insn;
    logic [lc4_pkg::reg_sel_w-1:0] rs_sel;
    logic [lc4_pkg::reg_sel_w-1:0] rt_sel;
    logic [lc4_pkg::reg_sel_w-1:0] rd_sel;
    logic [lc4_pkg::word_w-1:0]    rs_data;
    logic [lc4_pkg::word_w-1:0]    rt_data;
    logic                          regfile_we;
    logic                          is_load;
    logic                          is_store;
    logic [1:0]                    stall;

    modport producer (
        output pc, insn, rs_sel, rt_sel, rd_sel, rs_data, rt_data,
        output regfile_we, is_load, is_store, stall
    );

    modport consumer (
        input pc, insn, rs_sel, rt_sel, rd_sel, rs_data, rt_data,
        input regfile_we, is_load, is_store, stall
    );

endinterface

// File: rtl/lc4_fwd_if.sv
`timescale 1ns/1ps

interface lc4_fwd_if;

    // memory stage result
    logic [lc4_pkg::reg_sel_w-1:0] m_rd;
    logic                          m_we;
    logic [lc4_pkg::word_w-1:0]    m_result;

    // writeback stage result that also drives the register file write port
    logic [lc4_pkg::reg_sel_w-1:0] w_rd;
    logic                          w_we;
    logic [lc4_pkg::word_w-1:0]    w_data;

    modport producer (
        output m_rd, m_we, m_result,
        output w_rd, w_we, w_data
    );

    modport consumer (
        input m_rd, m_we, m_result,
        input w_rd, w_we, w_data
    );

endinterface

// File: rtl/lc4_pkg.sv
package lc4_pkg;

    localparam int word_w    = 16;
    localparam int reg_sel_w = 3;
    localparam int num_regs  = 8;
    localparam int nzp_w     = 3;

    localparam logic [word_w-1:0] reset_pc = 16'h8200;

    // major opcodes of the supported subset
    localparam logic [3:0] op_nop   = 4'b0000;
    localparam logic [3:0] op_arith = 4'b0001;
    localparam logic [3:0] op_logic = 4'b0101;
    localparam logic [3:0] op_ldr   = 4'b0110;
    localparam logic [3:0] op_str   = 4'b0111;
    localparam logic [3:0] op_const = 4'b1001;

    // trace stall codes
    localparam logic [1:0] stall_none  = 2'd0;
    localparam logic [1:0] stall_flush = 2'd2;
    localparam logic [1:0] stall_load  = 2'd3;

    localparam logic [nzp_w-1:0] nzp_p = 3'b001;
    localparam logic [nzp_w-1:0] nzp_z = 3'b010;
    localparam logic [nzp_w-1:0] nzp_n = 3'b100;

    // one instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [reg_sel_w-1:0] rs;
            logic [2:0]           subop;
            logic [reg_sel_w-1:0] rt;
        } r;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [reg_sel_w-1:0] rs;
            logic                 imm_flag;
            logic [4:0]           imm5;
        } i;
        struct packed {
            logic [3:0]           opcode;
            // destination for LDR, store data for STR
            logic [reg_sel_w-1:0] rd;
            logic [reg_sel_w-1:0] rs;
            logic [5:0]           off6;
        } m;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [8:0]           imm9;
        } c;
    } lc4_insn_u;

endpackage
